//--- files.f
rtl/video_pkg.sv
rtl/pix_bus_if.sv
rtl/video_input_stage.sv
rtl/scandoubler.sv
rtl/video_out_select.sv
rtl/mist_video.sv
tests/tb_clock_gen.sv
tests/tb_mist_video.sv

//--- rtl/mist_video.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Video output pipeline top
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module mist_video import video_pkg::*; (
	input  logic                 clk_sys,
	input  logic                 arst_n,
	// dimming of the repeated line
	input  scanline_t            scanlines,
	// input pixel strobe and doubled rate strobe
	input  logic                 ce_x1,
	input  logic                 ce_x2,
	// high sends core video straight out
	input  logic                 scandoubler_disable,
	// composite-like blending
	input  logic                 blend,
	// core video
	input  logic [IN_DEPTH-1:0]  r,
	input  logic [IN_DEPTH-1:0]  g,
	input  logic [IN_DEPTH-1:0]  b,
	input  logic                 hsync,
	input  logic                 vsync,
	// VGA pins
	output logic [OUT_DEPTH-1:0] vga_r,
	output logic [OUT_DEPTH-1:0] vga_g,
	output logic [OUT_DEPTH-1:0] vga_b,
	output logic                 vga_hs,
	output logic                 vga_vs
);

	pix_bus_if in_bus ();
	pix_bus_if sd_bus ();

	logic line_start;
	rgb_t vga_pix;

	video_input_stage i_video_input_stage (
		.clk_sys    (clk_sys),
		.arst_n     (arst_n),
		.ce_x1      (ce_x1),
		.r          (r),
		.g          (g),
		.b          (b),
		.hsync      (hsync),
		.vsync      (vsync),
		.out        (in_bus.source),
		.line_start (line_start)
	);

	scandoubler i_scandoubler (
		.clk_sys    (clk_sys),
		.arst_n     (arst_n),
		.ce_x2      (ce_x2),
		.scanlines  (scanlines),
		.line_start (line_start),
		.in         (in_bus.sink),
		.out        (sd_bus.source)
	);

	video_out_select i_video_out_select (
		.clk_sys             (clk_sys),
		.arst_n              (arst_n),
		.scandoubler_disable (scandoubler_disable),
		.blend               (blend),
		.bypass              (in_bus.sink),
		.doubled             (sd_bus.sink),
		.vga_pix             (vga_pix),
		.vga_hs              (vga_hs),
		.vga_vs              (vga_vs)
	);

	// split the pixel onto the colour pins
	assign vga_r = vga_pix.r;
	assign vga_g = vga_pix.g;
	assign vga_b = vga_pix.b;

endmodule

`default_nettype wire

//--- rtl/pix_bus_if.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Pixel bus
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

interface pix_bus_if import video_pkg::*; ();

	// colour of the current pixel
	rgb_t pix;

	// active-low sync levels
	logic hs;
	logic vs;

	// one-cycle pulse when pix carries a new pixel
	logic stb;

	// producer side
	modport source (
		output pix,
		output hs,
		output vs,
		output stb
	);

	// consumer side
	modport sink (
		input pix,
		input hs,
		input vs,
		input stb
	);

endinterface

`default_nettype wire

//--- rtl/scandoubler.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Line buffer scandoubler
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module scandoubler import video_pkg::*; (
	input  logic      clk_sys,
	input  logic      arst_n,
	input  logic      ce_x2,
	input  scanline_t scanlines,
	input  logic      line_start,
	pix_bus_if.sink   in,
	pix_bus_if.source out
);

	// dim one channel of the repeated line
	function automatic logic [OUT_DEPTH-1:0] dim_chan(
		input logic [OUT_DEPTH-1:0] x,
		input scanline_t            mode
	);
		logic [OUT_DEPTH-1:0] y;
		case (mode)
			SL_25:   y = x - (x >> 2);
			SL_50:   y = x >> 1;
			SL_75:   y = x >> 2;
			default: y = x;
		endcase
		return y;
	endfunction

	// two line banks, one written while the other is replayed
	rgb_t line_mem [0:1][0:LINE_WORDS-1];

	// bank being written, the other one is read
	logic wr_bank;

	// write side counters of the line in progress
	logic [HCNT_WIDTH-1:0] wr_cnt;
	logic [HCNT_WIDTH-1:0] hs_cnt;

	// geometry of the finished line
	logic [HCNT_WIDTH-1:0] line_len;
	logic [HCNT_WIDTH-1:0] hs_len;

	// read side
	logic [HCNT_WIDTH-1:0] rd_addr;
	logic                  second;
	logic                  rd_active;
	rgb_t                  rd_pix;

	// a line start pixel opens the next bank at address 0
	logic                  wr_sel;
	logic [HCNT_WIDTH-1:0] wr_addr;

	assign wr_sel  = line_start ? ~wr_bank : wr_bank;
	assign wr_addr = line_start ? '0 : wr_cnt;

	always_ff @(posedge clk_sys) begin
		if (in.stb) begin
			line_mem[wr_sel][wr_addr] <= in.pix;
		end
	end

	// counters and bank swap
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			wr_bank  <= 1'b0;
			wr_cnt   <= '0;
			hs_cnt   <= '0;
			line_len <= '0;
			hs_len   <= '0;
		end else if (in.stb) begin
			if (line_start) begin
				wr_bank  <= ~wr_bank;
				line_len <= wr_cnt;
				hs_len   <= hs_cnt;
				// the start pixel is the first one of the new line
				wr_cnt   <= HCNT_WIDTH'(1);
				hs_cnt   <= in.hs ? '0 : HCNT_WIDTH'(1);
			end else begin
				wr_cnt <= wr_cnt + 1'b1;
				if (!in.hs) begin
					hs_cnt <= hs_cnt + 1'b1;
				end
			end
		end
	end

	// replay from the bank that just filled
	assign rd_pix    = line_mem[~wr_bank][rd_addr];
	assign rd_active = rd_addr < line_len;

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			rd_addr <= '0;
			second  <= 1'b0;
		end else if (line_start) begin
			rd_addr <= '0;
			second  <= 1'b0;
		end else if (ce_x2 && rd_active) begin
			// end of first copy restarts the line as the second copy
			if (!second && rd_addr == line_len - 1'b1) begin
				rd_addr <= '0;
				second  <= 1'b1;
			end else begin
				rd_addr <= rd_addr + 1'b1;
			end
		end
	end

	// output register, one cycle after ce_x2
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			out.pix <= '0;
			out.hs  <= 1'b1;
			out.vs  <= 1'b1;
			out.stb <= 1'b0;
		end else begin
			out.stb <= ce_x2;
			// vsync held per line
			if (line_start) begin
				out.vs <= in.vs;
			end
			if (ce_x2) begin
				if (rd_active) begin
					out.pix.r <= second ? dim_chan(rd_pix.r, scanlines) : rd_pix.r;
					out.pix.g <= second ? dim_chan(rd_pix.g, scanlines) : rd_pix.g;
					out.pix.b <= second ? dim_chan(rd_pix.b, scanlines) : rd_pix.b;
					out.hs    <= ~(rd_addr < hs_len);
				end else begin
					// past the end of both copies
					out.pix <= '0;
					out.hs  <= 1'b1;
				end
			end
		end
	end

	// a pixel written without a line start must not roll the counter over
	a_no_wrap: assert property (@(posedge clk_sys) disable iff (!arst_n)
		in.stb && !line_start |=> wr_cnt != '0);

	// every input pixel strobe comes from a cycle where ce_x2 was also set
	a_ce_x2_covers_x1: assert property (@(posedge clk_sys) disable iff (!arst_n)
		in.stb |-> $past(ce_x2));

endmodule

`default_nettype wire

//--- rtl/video_input_stage.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Core pixel input stage
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module video_input_stage import video_pkg::*; (
	input  logic                clk_sys,
	input  logic                arst_n,
	input  logic                ce_x1,
	input  logic [IN_DEPTH-1:0] r,
	input  logic [IN_DEPTH-1:0] g,
	input  logic [IN_DEPTH-1:0] b,
	input  logic                hsync,
	input  logic                vsync,
	pix_bus_if.source           out,
	output logic                line_start
);

	// widen one channel by repeating its top bits below it
	function automatic logic [OUT_DEPTH-1:0] widen(input logic [IN_DEPTH-1:0] c);
		return {c, c[IN_DEPTH-1 -: (OUT_DEPTH-IN_DEPTH)]};
	endfunction

	// hsync as seen on the previous ce_x1
	logic hs_prev;

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			out.pix    <= '0;
			out.hs     <= 1'b1;
			out.vs     <= 1'b1;
			out.stb    <= 1'b0;
			line_start <= 1'b0;
			hs_prev    <= 1'b1;
		end else begin
			// strobe follows ce_x1 by one cycle
			out.stb    <= ce_x1;
			line_start <= ce_x1 & hs_prev & ~hsync;
			if (ce_x1) begin
				out.pix.r <= widen(r);
				out.pix.g <= widen(g);
				out.pix.b <= widen(b);
				out.hs    <= hsync;
				out.vs    <= vsync;
				hs_prev   <= hsync;
			end
		end
	end

	// a line start is always a fresh pixel that already carries hsync low
	a_line_start_stb: assert property (@(posedge clk_sys) disable iff (!arst_n)
		line_start |-> out.stb && !out.hs);

endmodule

`default_nettype wire

//--- rtl/video_out_select.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// VGA output select and blend
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module video_out_select import video_pkg::*; (
	input  logic    clk_sys,
	input  logic    arst_n,
	input  logic    scandoubler_disable,
	input  logic    blend,
	pix_bus_if.sink bypass,
	pix_bus_if.sink doubled,
	output rgb_t    vga_pix,
	output logic    vga_hs,
	output logic    vga_vs
);

	// mean of two channels, rounded down
	function automatic logic [OUT_DEPTH-1:0] avg(
		input logic [OUT_DEPTH-1:0] a,
		input logic [OUT_DEPTH-1:0] c
	);
		logic [OUT_DEPTH:0] sum;
		sum = {1'b0, a} + {1'b0, c};
		return sum[OUT_DEPTH:1];
	endfunction

	rgb_t sel_pix;
	logic sel_hs;
	logic sel_vs;
	logic sel_stb;

	// last_pix holds the newest taken pixel, prev_pix the one before it
	rgb_t last_pix;
	rgb_t prev_pix;
	rgb_t partner;
	rgb_t mix;

	always_comb begin
		sel_pix = scandoubler_disable ? bypass.pix : doubled.pix;
		sel_hs  = scandoubler_disable ? bypass.hs  : doubled.hs;
		sel_vs  = scandoubler_disable ? bypass.vs  : doubled.vs;
		sel_stb = scandoubler_disable ? bypass.stb : doubled.stb;
		// on a strobe the bus already shows the new pixel
		partner = sel_stb ? last_pix : prev_pix;
		mix.r   = avg(sel_pix.r, partner.r);
		mix.g   = avg(sel_pix.g, partner.g);
		mix.b   = avg(sel_pix.b, partner.b);
	end

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			last_pix <= '0;
			prev_pix <= '0;
			vga_pix  <= '0;
			vga_hs   <= 1'b1;
			vga_vs   <= 1'b1;
		end else begin
			if (sel_stb) begin
				last_pix <= sel_pix;
				prev_pix <= last_pix;
			end
			vga_pix <= blend ? mix : sel_pix;
			// syncs pass unblended
			vga_hs  <= sel_hs;
			vga_vs  <= sel_vs;
		end
	end

endmodule

`default_nettype wire

//--- rtl/video_pkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Video pipeline shared definitions
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package video_pkg;

	// bits per colour channel coming from the core
	localparam int IN_DEPTH = 4;

	// bits per colour channel on the VGA pins
	localparam int OUT_DEPTH = 6;

	// line buffer pixel counter width
	localparam int HCNT_WIDTH = 9;

	// words per line buffer bank
	localparam int LINE_WORDS = 2 ** HCNT_WIDTH;

	// one full-depth pixel
	typedef struct packed {
		logic [OUT_DEPTH-1:0] r;
		logic [OUT_DEPTH-1:0] g;
		logic [OUT_DEPTH-1:0] b;
	} rgb_t;

	// scanline dimming of the repeated line
	// the name gives the share of brightness removed
	typedef enum logic [1:0] {
		SL_NONE = 2'b00,
		SL_25   = 2'b01,
		SL_50   = 2'b10,
		SL_75   = 2'b11
	} scanline_t;

endpackage

`default_nettype wire

//--- run_sim.sh
#!/usr/bin/env bash
# build the mist_video testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
	--top-module tb_mist_video \
	-f files.f

# a fatal stop returns non-zero, keep the output for the search below
output=$(./obj_dir/Vtb_mist_video 2>&1 || true)
echo "$output"

if echo "$output" | grep -q "^No errors$"; then
	exit 0
else
	exit 1
fi

//--- tests/tb_clock_gen.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench clock and reset
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
	output logic clk_sys,
	output logic arst_n
);

	// 8 ns period
	localparam int HALF_PERIOD_NS = 4;
	localparam int RESET_CYCLES   = 3;

	initial begin
		clk_sys = 1'b0;
		forever begin
			#(HALF_PERIOD_NS);
			clk_sys = ~clk_sys;
		end
	end

	// release just after an edge, away from the sampling point
	initial begin
		arst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk_sys);
		#1;
		arst_n = 1'b1;
	end

endmodule

`default_nettype wire

//--- tests/tb_mist_video.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Video pipeline testbench
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module tb_mist_video import video_pkg::*; ();

	localparam int          NUM_ROWS        = 8;
	localparam int          DRIVE_DELAY     = 1;
	localparam int          WATCHDOG_MARGIN = 200;
	localparam logic [31:0] SEED            = 32'h7f2b_da3f;

	// one test case with lengths counted in input pixels
	typedef struct packed {
		logic      sd_disable;
		logic      blend;
		scanline_t sl;
		int        line_len;
		int        hs_width;
		int        lines;
	} row_t;

	logic                 clk_sys;
	logic                 arst_n;
	scanline_t            scanlines;
	logic                 ce_x1;
	logic                 ce_x2;
	logic                 scandoubler_disable;
	logic                 blend;
	logic [IN_DEPTH-1:0]  r;
	logic [IN_DEPTH-1:0]  g;
	logic [IN_DEPTH-1:0]  b;
	logic                 hsync;
	logic                 vsync;
	logic [OUT_DEPTH-1:0] vga_r;
	logic [OUT_DEPTH-1:0] vga_g;
	logic [OUT_DEPTH-1:0] vga_b;
	logic                 vga_hs;
	logic                 vga_vs;

	row_t      rows [NUM_ROWS];
	logic      row_dis;
	logic      row_blend;
	scanline_t row_sl;
	int        watchdog_cycles;

	// reference model state as seen in the current cycle
	rgb_t a_pix;
	logic a_hs;
	logic a_vs;
	logic a_stb;
	logic a_ls;
	logic a_hs_seen;
	// line being captured and line being replayed
	rgb_t line_acc [$];
	int   line_hs_low;
	rgb_t replay [$];
	int   replay_hs;
	// ce_x2 pixels emitted since the last line start
	int   rd_pos;
	rgb_t sd_pix;
	logic sd_hs;
	logic sd_vs;
	logic sd_stb;
	// last two pixels taken by the output stage
	rgb_t taken_last;
	rgb_t taken_prev;
	// expected pins
	rgb_t exp_pix;
	logic exp_hs;
	logic exp_vs;

	tb_clock_gen i_tb_clock_gen (
		.clk_sys (clk_sys),
		.arst_n  (arst_n)
	);

	mist_video i_mist_video (
		.clk_sys             (clk_sys),
		.arst_n              (arst_n),
		.scanlines           (scanlines),
		.ce_x1               (ce_x1),
		.ce_x2               (ce_x2),
		.scandoubler_disable (scandoubler_disable),
		.blend               (blend),
		.r                   (r),
		.g                   (g),
		.b                   (b),
		.hsync               (hsync),
		.vsync               (vsync),
		.vga_r               (vga_r),
		.vga_g               (vga_g),
		.vga_b               (vga_b),
		.vga_hs              (vga_hs),
		.vga_vs              (vga_vs)
	);

	// colour widening appends the value's own top bits
	function automatic logic [OUT_DEPTH-1:0] widen_ref(input logic [IN_DEPTH-1:0] c);
		return OUT_DEPTH'((int'(c) << (OUT_DEPTH - IN_DEPTH))
			| (int'(c) >> (2 * IN_DEPTH - OUT_DEPTH)));
	endfunction

	// brightness kept on the repeated line with truncating division
	function automatic logic [OUT_DEPTH-1:0] dim_ref(
		input logic [OUT_DEPTH-1:0] x,
		input scanline_t            mode
	);
		int v;
		v = int'(x);
		case (mode)
			SL_25:   v = v - v / 4;
			SL_50:   v = v / 2;
			SL_75:   v = v / 4;
			default: v = v;
		endcase
		return OUT_DEPTH'(v);
	endfunction

	function automatic logic [OUT_DEPTH-1:0] avg_ref(
		input logic [OUT_DEPTH-1:0] x,
		input logic [OUT_DEPTH-1:0] y
	);
		return OUT_DEPTH'((int'(x) + int'(y)) / 2);
	endfunction

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("Errors found");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_pix(input string name, input rgb_t got, input rgb_t want);
		if (got !== want) begin
			fail_run($sformatf("mismatch %s: got %h expected %h at %0t",
				name, got, want, $time));
		end
	endtask

	task automatic check_sync(
		input logic got_hs,
		input logic got_vs,
		input logic want_hs,
		input logic want_vs
	);
		if (got_hs !== want_hs) begin
			fail_run($sformatf("mismatch vga_hs: got %h expected %h at %0t",
				got_hs, want_hs, $time));
		end
		if (got_vs !== want_vs) begin
			fail_run($sformatf("mismatch vga_vs: got %h expected %h at %0t",
				got_vs, want_vs, $time));
		end
	endtask

	// disable, blend, scanlines, pixels per line, hsync width, lines
	task automatic load_rows();
		rows[0] = '{1'b1, 1'b0, SL_NONE, 16, 3, 3};
		rows[1] = '{1'b1, 1'b1, SL_NONE, 16, 3, 3};
		rows[2] = '{1'b0, 1'b0, SL_NONE, 20, 4, 4};
		rows[3] = '{1'b0, 1'b0, SL_25, 20, 4, 3};
		rows[4] = '{1'b0, 1'b0, SL_50, 24, 5, 3};
		rows[5] = '{1'b0, 1'b0, SL_75, 24, 5, 3};
		rows[6] = '{1'b0, 1'b1, SL_50, 16, 2, 3};
		rows[7] = '{1'b1, 1'b0, SL_75, 12, 2, 2};
	endtask

	task automatic reset_model();
		a_pix       = '0;
		a_hs        = 1'b1;
		a_vs        = 1'b1;
		a_stb       = 1'b0;
		a_ls        = 1'b0;
		a_hs_seen   = 1'b1;
		line_acc.delete();
		line_hs_low = 0;
		replay.delete();
		replay_hs   = 0;
		rd_pos      = 0;
		sd_pix      = '0;
		sd_hs       = 1'b1;
		sd_vs       = 1'b1;
		sd_stb      = 1'b0;
		taken_last  = '0;
		taken_prev  = '0;
		exp_pix     = '0;
		exp_hs      = 1'b1;
		exp_vs      = 1'b1;
	endtask

	// advance the model by one clock edge with the later stages first
	task automatic step_model();
		rgb_t sel;
		logic sel_hs;
		logic sel_vs;
		logic sel_stb;
		rgb_t mix;
		rgb_t rd;
		int   len;
		int   idx;
		// output stage picks a stream and blends with the pixel before
		sel     = scandoubler_disable ? a_pix : sd_pix;
		sel_hs  = scandoubler_disable ? a_hs : sd_hs;
		sel_vs  = scandoubler_disable ? a_vs : sd_vs;
		sel_stb = scandoubler_disable ? a_stb : sd_stb;
		if (sel_stb) begin
			taken_prev = taken_last;
			taken_last = sel;
		end
		mix.r   = avg_ref(sel.r, taken_prev.r);
		mix.g   = avg_ref(sel.g, taken_prev.g);
		mix.b   = avg_ref(sel.b, taken_prev.b);
		exp_pix = blend ? mix : sel;
		exp_hs  = sel_hs;
		exp_vs  = sel_vs;
		// doubled stream gives two copies of the stored line then black
		len = replay.size();
		if (a_ls) begin
			sd_vs = a_vs;
		end
		if (ce_x2) begin
			if (rd_pos < 2 * len) begin
				idx = rd_pos % len;
				rd  = replay[idx];
				if (rd_pos >= len) begin
					rd.r = dim_ref(rd.r, scanlines);
					rd.g = dim_ref(rd.g, scanlines);
					rd.b = dim_ref(rd.b, scanlines);
				end
				sd_pix = rd;
				sd_hs  = idx >= replay_hs;
			end else begin
				sd_pix = '0;
				sd_hs  = 1'b1;
			end
		end
		sd_stb = ce_x2;
		if (a_ls) begin
			rd_pos = 0;
		end else if (ce_x2) begin
			rd_pos++;
		end
		// a line start hands the finished line over to the replay
		if (a_stb) begin
			if (a_ls) begin
				replay      = line_acc;
				replay_hs   = line_hs_low;
				line_acc.delete();
				line_hs_low = 0;
			end
			line_acc.push_back(a_pix);
			if (!a_hs) begin
				line_hs_low++;
			end
		end
		// input register
		a_stb = ce_x1;
		a_ls  = ce_x1 && a_hs_seen && !hsync;
		if (ce_x1) begin
			a_pix.r   = widen_ref(r);
			a_pix.g   = widen_ref(g);
			a_pix.b   = widen_ref(b);
			a_hs      = hsync;
			a_vs      = vsync;
			a_hs_seen = hsync;
		end
	endtask

	// check the pins of this cycle and drive the next inputs
	task automatic run_cycle(
		input logic ce1,
		input logic ce2,
		input logic hs_lvl,
		input logic vs_lvl
	);
		@(posedge clk_sys);
		#(DRIVE_DELAY);
		check_pix("vga_rgb", {vga_r, vga_g, vga_b}, exp_pix);
		check_sync(vga_hs, vga_vs, exp_hs, exp_vs);
		scandoubler_disable = row_dis;
		blend               = row_blend;
		scanlines           = row_sl;
		ce_x1               = ce1;
		ce_x2               = ce2;
		hsync               = hs_lvl;
		vsync               = vs_lvl;
		// colour changes every cycle but only ce_x1 picks it up
		r = IN_DEPTH'($urandom);
		g = IN_DEPTH'($urandom);
		b = IN_DEPTH'($urandom);
		step_model();
	endtask

	initial begin
		int   k;
		int   ln;
		int   px;
		int   total;
		logic hs_lvl;
		logic vs_lvl;
		scanlines           = SL_NONE;
		ce_x1               = 1'b0;
		ce_x2               = 1'b0;
		scandoubler_disable = 1'b1;
		blend               = 1'b0;
		r                   = '0;
		g                   = '0;
		b                   = '0;
		hsync               = 1'b1;
		vsync               = 1'b1;
		row_dis             = 1'b1;
		row_blend           = 1'b0;
		row_sl              = SL_NONE;
		void'($urandom(SEED));
		load_rows();
		reset_model();
		total = WATCHDOG_MARGIN;
		for (k = 0; k < NUM_ROWS; k++) begin
			total += rows[k].lines * rows[k].line_len * 4;
		end
		watchdog_cycles = total;
		// pins during reset
		repeat (2) @(posedge clk_sys);
		#(DRIVE_DELAY);
		check_pix("vga_rgb", {vga_r, vga_g, vga_b}, '0);
		check_sync(vga_hs, vga_vs, 1'b1, 1'b1);
		@(posedge arst_n);
		for (k = 0; k < NUM_ROWS; k++) begin
			row_dis   = rows[k].sd_disable;
			row_blend = rows[k].blend;
			row_sl    = rows[k].sl;
			for (ln = 0; ln < rows[k].lines; ln++) begin
				// vsync pulse on the second line of every case
				vs_lvl = ln != 1;
				for (px = 0; px < rows[k].line_len; px++) begin
					hs_lvl = px >= rows[k].hs_width;
					// ce_x1 one cycle in four and ce_x2 every second cycle
					run_cycle(1'b1, 1'b1, hs_lvl, vs_lvl);
					run_cycle(1'b0, 1'b0, hs_lvl, vs_lvl);
					run_cycle(1'b0, 1'b1, hs_lvl, vs_lvl);
					run_cycle(1'b0, 1'b0, hs_lvl, vs_lvl);
				end
			end
		end
		// let the last pixels reach the pins
		repeat (8) run_cycle(1'b0, 1'b0, 1'b1, 1'b1);
		$display("No errors");
		$finish;
	end

	// watchdog sized from the stimulus table
	initial begin
		wait (watchdog_cycles > 0);
		repeat (watchdog_cycles) @(posedge clk_sys);
		fail_run($sformatf("timeout: stimulus did not finish within %0d clock cycles",
			watchdog_cycles));
	end

endmodule

`default_nettype wire
